// File: project.f
+incdir+sim
src/taint_pkg.sv
src/taint_op_cell.sv
src/taint_result_reg.sv
src/taint_shadow_mem.sv
src/taint_liveness_count.sv
src/taint_track_top.sv
sim/tb_taint_track.sv

// File: run_sim.sh
#!/bin/sh
# builds the testbench with Verilator, runs it and looks for the pass line in the log
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --top-module tb_taint_track -f project.f -o tb_taint_track

./obj_dir/tb_taint_track > sim.log
cat sim.log

grep -qx "ALL TESTS PASSED" sim.log
echo "run_sim: log holds the pass line"

// File: sim/taint_model.svh
`ifndef TAINT_MODEL_SVH
`define TAINT_MODEL_SVH

// reference copies of the result register and the shadow array
op_res_t model_res;
taint_t  model_mem [mem_depth];

function automatic void model_reset();
    model_res = '0;
    for (int i = 0; i < mem_depth; i++) begin
        model_mem[i] = '0;
    end
endfunction

function automatic op_res_t model_op(op_req_t r);
    op_res_t o;
    logic    clean_eq;
    o = '0;
    clean_eq = 1'b1;
    case (r.op)
        op_and, op_or: begin
            o.value = (r.op == op_and) ? (r.a & r.b) : (r.a | r.b);
            for (int i = 0; i < data_w; i++) begin
                // a tainted bit shows through unless the other clean side masks it
                if (r.op == op_and) begin
                    o.taint[i] = (r.a_taint[i] && (r.b[i] || r.b_taint[i]))
                               || (r.b_taint[i] && r.a[i]);
                end else begin
                    o.taint[i] = (r.a_taint[i] && (!r.b[i] || r.b_taint[i]))
                               || (r.b_taint[i] && !r.a[i]);
                end
            end
        end
        op_add: begin
            o.value = r.a + r.b;
            o.taint = ((r.a & ~r.a_taint) + (r.b & ~r.b_taint))
                    ^ ((r.a | r.a_taint) + (r.b | r.b_taint)) | r.a_taint | r.b_taint;
        end
        op_sub: begin
            o.value = r.a - r.b;
            o.taint = ((r.a & ~r.a_taint) - (r.b & ~r.b_taint))
                    ^ ((r.a | r.a_taint) - (r.b | r.b_taint)) | r.a_taint | r.b_taint;
        end
        op_shl: begin
            o.value = r.a << r.b;
            o.taint = (r.b_taint != '0) ? '1 : (r.a_taint << r.b);
        end
        op_shr: begin
            o.value = r.a >> r.b;
            o.taint = (r.b_taint != '0) ? '1 : (r.a_taint >> r.b);
        end
        op_eq: begin
            o.value[0] = (r.a == r.b);
            for (int i = 0; i < data_w; i++) begin
                if (!r.a_taint[i] && !r.b_taint[i] && (r.a[i] != r.b[i])) begin
                    clean_eq = 1'b0;
                end
            end
            o.taint[0] = ((r.a_taint | r.b_taint) != '0) && clean_eq;
        end
        op_red_or: begin
            o.value[0] = (r.a != '0);
            o.taint[0] = (r.a_taint != '0) && ((r.a & ~r.a_taint) == '0);
        end
        op_red_and: begin
            o.value[0] = (r.a == '1);
            o.taint[0] = ((r.a | r.a_taint) == '1) && (r.a_taint != '0);
        end
        op_red_xor: begin
            o.value[0] = ^r.a;
            o.taint[0] = (r.a_taint != '0);
        end
        op_mux: begin
            o.value = r.sel ? r.b : r.a;
            o.taint = r.sel ? r.b_taint : r.a_taint;
            if (r.sel_taint) begin
                o.taint = o.taint | (r.a ^ r.b);
            end
        end
        default: ;
    endcase
    return o;
endfunction

// hold-or-load with the enable possibly tainted
function automatic op_res_t model_result_step(op_res_t d, logic en, logic en_taint);
    taint_t flow;
    flow = en_taint ? (d.value ^ model_res.value) : '0;
    if (en) begin
        model_res.value = d.value;
        model_res.taint = d.taint | flow;
    end else begin
        model_res.taint = model_res.taint | flow;
    end
    return model_res;
endfunction

function automatic taint_t model_read(mem_rd_t r);
    if (r.en_taint) begin
        return '1;
    end
    if (!r.en) begin
        return '0;
    end
    return (r.addr_taint != '0) ? '1 : model_mem[r.addr];
endfunction

function automatic void model_write(mem_wr_t w);
    for (int i = 0; i < data_w; i++) begin
        if (w.addr_taint != '0 || w.en_taint[i]) begin
            model_mem[w.addr][i] = 1'b1;
        end else if (w.en[i]) begin
            model_mem[w.addr][i] = w.data_taint[i];
        end
    end
endfunction

function automatic count_t model_live(live_ctl_t c);
    count_t n;
    logic   live;
    n = '0;
    for (int i = 0; i < mem_depth; i++) begin
        if (c.mode == live_bitmap) begin
            live = c.bitmap[i];
        end else if (c.rd_ptr < c.wr_ptr) begin
            live = (i >= int'(c.rd_ptr)) && (i < int'(c.wr_ptr));
        end else if (c.wr_ptr < c.rd_ptr) begin
            live = (i >= int'(c.rd_ptr)) || (i < int'(c.wr_ptr));
        end else begin
            live = c.full;
        end
        if (live && (model_mem[i] != '0)) begin
            n = n + count_t'(1);
        end
    end
    return n;
endfunction

`endif

// File: sim/tb_taint_track.sv
`timescale 1ns/1ps
`default_nettype none

module tb_taint_track;
    import taint_pkg::*;

    logic      pos_clk;
    logic      pos_arst;
    op_req_t   op_req;
    op_res_t   result;
    mem_wr_t   mem_wr;
    mem_rd_t   mem_rd;
    taint_t    rd_taint;
    live_ctl_t live_ctl;
    count_t    live_count;

    `include "taint_model.svh"

    // expectations for the vector that the next edge samples
    logic        pending;
    op_res_t     exp_result;
    taint_t      exp_rd;
    count_t      exp_count;
    string       test_name;
    int          test_errs;
    int          total_errs;
    int          tests_run;
    int          tests_failed;

    taint_track_top dut0 (
        .pos_clk    (pos_clk),
        .pos_arst   (pos_arst),
        .op_req     (op_req),
        .result     (result),
        .mem_wr     (mem_wr),
        .mem_rd     (mem_rd),
        .rd_taint   (rd_taint),
        .live_ctl   (live_ctl),
        .live_count (live_count)
    );

    initial begin
        pos_clk = 1'b0;
        forever begin
            #5 pos_clk = ~pos_clk;
        end
    end

    // about a quarter of the bits, and clean a quarter of the time
    function automatic taint_t sparse_mask();
        if ($urandom_range(3, 0) == 0) begin
            return '0;
        end
        return taint_t'($urandom & $urandom);
    endfunction

    function automatic op_req_t rand_req(logic rand_en);
        op_req_t r;
        r.op      = taint_op_e'(4'($urandom_range(10, 0)));
        r.a       = data_t'($urandom);
        r.a_taint = sparse_mask();
        r.b_taint = ($urandom_range(1, 0) == 0) ? '0 : sparse_mask();
        // small shift amounts keep some shifted taint in the word
        r.b = ($urandom_range(1, 0) == 0) ? data_t'($urandom_range(17, 0)) : data_t'($urandom);
        if ($urandom_range(3, 0) == 0) begin
            // b differs from a only in tainted bits
            r.b = r.a ^ (r.a_taint & data_t'($urandom));
        end
        r.sel       = 1'($urandom_range(1, 0));
        r.sel_taint = 1'($urandom_range(1, 0));
        r.en        = rand_en ? 1'($urandom_range(1, 0)) : 1'b1;
        r.en_taint  = rand_en ? 1'($urandom_range(1, 0)) : 1'b0;
        return r;
    endfunction

    function automatic mem_wr_t rand_wr();
        mem_wr_t w;
        w.addr       = addr_t'($urandom);
        w.addr_taint = ($urandom_range(7, 0) == 0) ? addr_t'($urandom_range(15, 1)) : '0;
        if ($urandom_range(2, 0) == 0) begin
            // clearing write lets a word drop back to untainted
            w.en         = '1;
            w.en_taint   = '0;
            w.data_taint = '0;
        end else begin
            w.en         = taint_t'($urandom);
            w.en_taint   = ($urandom_range(3, 0) == 0) ? taint_t'($urandom & $urandom) : '0;
            w.data_taint = taint_t'($urandom);
        end
        return w;
    endfunction

    function automatic mem_rd_t rand_rd(addr_t wr_addr);
        mem_rd_t r;
        r.en         = 1'($urandom_range(3, 0) != 0);
        r.en_taint   = 1'($urandom_range(7, 0) == 0);
        r.addr       = ($urandom_range(3, 0) == 0) ? wr_addr : addr_t'($urandom);
        r.addr_taint = ($urandom_range(7, 0) == 0) ? addr_t'($urandom_range(15, 1)) : '0;
        return r;
    endfunction

    function automatic live_ctl_t rand_ctl(live_mode_e mode);
        live_ctl_t c;
        c.mode   = mode;
        c.bitmap = 16'($urandom);
        c.wr_ptr = addr_t'($urandom);
        // equal pointers a quarter of the time so that full decides
        c.rd_ptr = ($urandom_range(3, 0) == 0) ? c.wr_ptr : addr_t'($urandom);
        c.full   = 1'($urandom_range(1, 0));
        return c;
    endfunction

    task automatic start_test(string name);
        test_name = name;
        test_errs = 0;
    endtask

    // drive one vector, check the previous one, then predict this one
    task automatic step(op_req_t r, mem_wr_t w, mem_rd_t rd, live_ctl_t c);
        @(posedge pos_clk);
        op_req   <= r;
        mem_wr   <= w;
        mem_rd   <= rd;
        live_ctl <= c;
        @(negedge pos_clk);
        if (pending) begin
            if (result !== exp_result) begin
                $display("ERR %s result: expected %h, actual %h", test_name, exp_result, result);
                test_errs++;
            end
            if (rd_taint !== exp_rd) begin
                $display("ERR %s rd_taint: expected %h, actual %h", test_name, exp_rd, rd_taint);
                test_errs++;
            end
            if (live_count !== exp_count) begin
                $display("ERR %s live_count: expected %0d, actual %0d", test_name, exp_count,
                         live_count);
                test_errs++;
            end
        end
        exp_count  = model_live(c);
        exp_rd     = model_read(rd);
        model_write(w);
        exp_result = model_result_step(model_op(r), r.en, r.en_taint);
        pending    = 1'b1;
    endtask

    task automatic finish_test();
        // idle vector flushes the last check of the test
        step('0, '0, '0, '0);
        tests_run++;
        total_errs += test_errs;
        if (test_errs == 0) begin
            $display("test %s: ok", test_name);
        end else begin
            $display("test %s: %0d mismatches", test_name, test_errs);
            tests_failed++;
        end
    endtask

    task automatic wait_for_clear(int limit);
        int n;
        n = 0;
        while ((result !== '0 || rd_taint !== '0 || live_count !== '0) && n < limit) begin
            @(negedge pos_clk);
            n++;
        end
        if (result !== '0 || rd_taint !== '0 || live_count !== '0) begin
            $display("timeout: outputs did not clear within %0d cycles of reset", limit);
            test_errs++;
        end
    endtask

    initial begin
        mem_wr_t w;
        void'($urandom(32'hec70c330));
        pos_arst     = 1'b1;
        op_req       = '0;
        mem_wr       = '0;
        mem_rd       = '0;
        live_ctl     = '0;
        pending      = 1'b0;
        total_errs   = 0;
        tests_run    = 0;
        tests_failed = 0;
        model_reset();

        start_test("reset");
        wait_for_clear(5);
        repeat (5) @(posedge pos_clk);
        pos_arst <= 1'b0;
        @(negedge pos_clk);
        if (result !== '0) begin
            $display("ERR reset result: expected 0, actual %h", result);
            test_errs++;
        end
        if (rd_taint !== '0) begin
            $display("ERR reset rd_taint: expected 0, actual %h", rd_taint);
            test_errs++;
        end
        if (live_count !== '0) begin
            $display("ERR reset live_count: expected 0, actual %0d", live_count);
            test_errs++;
        end
        finish_test();

        start_test("op_propagation");
        repeat (400) step(rand_req(1'b0), '0, '0, '0);
        finish_test();

        start_test("tainted_enable");
        repeat (300) step(rand_req(1'b1), '0, '0, '0);
        finish_test();

        start_test("shadow_memory");
        repeat (300) begin
            w = rand_wr();
            step('0, w, rand_rd(w.addr), '0);
        end
        finish_test();

        start_test("bitmap_liveness");
        repeat (200) begin
            w = rand_wr();
            step('0, w, rand_rd(w.addr), rand_ctl(live_bitmap));
        end
        finish_test();

        start_test("queue_liveness");
        repeat (200) begin
            w = rand_wr();
            step('0, w, rand_rd(w.addr), rand_ctl(live_queue));
        end
        finish_test();

        $display("summary: %0d tests run, %0d failed, %0d mismatches", tests_run,
                 tests_failed, total_errs);
        if (tests_failed == 0) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: src/taint_liveness_count.sv
`timescale 1ns/1ps
`default_nettype none

module taint_liveness_count (
    input  logic                            pos_clk,
    input  logic                            pos_arst,
    input  taint_pkg::live_ctl_t            ctl,
    input  logic [taint_pkg::mem_depth-1:0] word_tainted,
    output taint_pkg::count_t               live_count
);
    import taint_pkg::*;

    logic [mem_depth-1:0] live;
    count_t               count_next;

    always_comb begin
        for (int i = 0; i < mem_depth; i++) begin
            if (ctl.mode == live_bitmap) begin
                live[i] = ctl.bitmap[i];
            end else if (ctl.rd_ptr < ctl.wr_ptr) begin
                live[i] = (i >= int'(ctl.rd_ptr)) && (i < int'(ctl.wr_ptr));
            end else if (ctl.wr_ptr < ctl.rd_ptr) begin
                // queue wrapped around the end of the array
                live[i] = (i >= int'(ctl.rd_ptr)) || (i < int'(ctl.wr_ptr));
            end else begin
                // equal pointers, empty or full
                live[i] = ctl.full;
            end
        end
    end

    always_comb begin
        count_next = '0;
        for (int i = 0; i < mem_depth; i++) begin
            count_next = count_next + count_t'(live[i] & word_tainted[i]);
        end
    end

    always_ff @(posedge pos_clk or posedge pos_arst) begin
        if (pos_arst) begin
            live_count <= '0;
        end else begin
            live_count <= count_next;
        end
    end

endmodule

`default_nettype wire

// File: src/taint_op_cell.sv
`timescale 1ns/1ps
`default_nettype none

module taint_op_cell (
    input  taint_pkg::op_req_t req,
    output taint_pkg::op_res_t res
);
    import taint_pkg::*;

    // operands with all tainted bits forced low, then forced high
    data_t  a_lo;
    data_t  a_hi;
    data_t  b_lo;
    data_t  b_hi;
    taint_t any_taint;
    logic   eq_clean;

    assign a_lo = req.a & ~req.a_taint;
    assign a_hi = req.a | req.a_taint;
    assign b_lo = req.b & ~req.b_taint;
    assign b_hi = req.b | req.b_taint;

    assign any_taint = req.a_taint | req.b_taint;
    // compare over the untainted bits only
    assign eq_clean  = (req.a & ~any_taint) == (req.b & ~any_taint);

    always_comb begin
        res = '0;
        case (req.op)
            op_and: begin
                res.value = req.a & req.b;
                res.taint = (req.a_taint & req.b) | (req.b_taint & req.a)
                          | (req.a_taint & req.b_taint);
            end
            op_or: begin
                res.value = req.a | req.b;
                res.taint = (req.a_taint & ~req.b) | (req.b_taint & ~req.a)
                          | (req.a_taint & req.b_taint);
            end
            op_add: begin
                res.value = req.a + req.b;
                res.taint = ((a_lo + b_lo) ^ (a_hi + b_hi)) | any_taint;
            end
            op_sub: begin
                res.value = req.a - req.b;
                res.taint = ((a_lo - b_lo) ^ (a_hi - b_hi)) | any_taint;
            end
            op_shl: begin
                res.value = req.a << req.b;
                res.taint = (|req.b_taint) ? '1 : taint_t'(req.a_taint << req.b);
            end
            op_shr: begin
                res.value = req.a >> req.b;
                res.taint = (|req.b_taint) ? '1 : taint_t'(req.a_taint >> req.b);
            end
            op_eq: begin
                // result could flip only if tainted bits decide it
                res.value = data_t'(req.a == req.b);
                res.taint = taint_t'((|any_taint) && eq_clean);
            end
            op_red_or: begin
                res.value = data_t'(|req.a);
                res.taint = taint_t'((|req.a_taint) && !(|a_lo));
            end
            op_red_and: begin
                res.value = data_t'(&req.a);
                res.taint = taint_t'((&a_hi) && (|req.a_taint));
            end
            op_red_xor: begin
                res.value = data_t'(^req.a);
                res.taint = taint_t'(|req.a_taint);
            end
            op_mux: begin
                res.value = req.sel ? req.b : req.a;
                res.taint = (req.sel ? req.b_taint : req.a_taint)
                          | (req.sel_taint ? taint_t'(req.a ^ req.b) : '0);
            end
            default: begin
                // unknown code, spread any taint over the word
                res.value = '0;
                res.taint = {data_w{|any_taint}};
            end
        endcase
    end

endmodule

`default_nettype wire

// File: src/taint_pkg.sv
`default_nettype none

package taint_pkg;

    localparam int data_w    = 16;
    localparam int addr_w    = 4;
    localparam int mem_depth = 16;
    // wide enough to hold 0 to mem_depth
    localparam int count_w   = 5;

    typedef logic [data_w-1:0]  data_t;
    // bit i set means data bit i is tainted
    typedef logic [data_w-1:0]  taint_t;
    typedef logic [addr_w-1:0]  addr_t;
    typedef logic [count_w-1:0] count_t;

    typedef enum logic [3:0] {
        op_and,
        op_or,
        op_add,
        op_sub,
        op_shl,
        op_shr,
        op_eq,
        op_red_or,
        op_red_and,
        op_red_xor,
        op_mux
    } taint_op_e;

    typedef enum logic [0:0] {
        live_bitmap,
        live_queue
    } live_mode_e;

    // compute request, en/en_taint drive the result register
    typedef struct packed {
        taint_op_e op;
        data_t     a;
        taint_t    a_taint;
        data_t     b;
        taint_t    b_taint;
        logic      sel;
        logic      sel_taint;
        logic      en;
        logic      en_taint;
    } op_req_t;

    typedef struct packed {
        data_t  value;
        taint_t taint;
    } op_res_t;

    // per-bit write enable and its taint
    typedef struct packed {
        taint_t en;
        taint_t en_taint;
        addr_t  addr;
        addr_t  addr_taint;
        taint_t data_taint;
    } mem_wr_t;

    typedef struct packed {
        logic  en;
        logic  en_taint;
        addr_t addr;
        addr_t addr_taint;
    } mem_rd_t;

    typedef struct packed {
        live_mode_e           mode;
        logic [mem_depth-1:0] bitmap;
        addr_t                wr_ptr;
        addr_t                rd_ptr;
        logic                 full;
    } live_ctl_t;

endpackage

`default_nettype wire

// File: src/taint_result_reg.sv
`timescale 1ns/1ps
`default_nettype none

module taint_result_reg (
    input  logic               pos_clk,
    input  logic               pos_arst,
    input  logic               en,
    input  logic               en_taint,
    input  taint_pkg::op_res_t d,
    output taint_pkg::op_res_t q
);
    import taint_pkg::*;

    // bits whose value depends on whether the enable fired
    taint_t en_flow;

    assign en_flow = en_taint ? taint_t'(d.value ^ q.value) : '0;

    always_ff @(posedge pos_clk or posedge pos_arst) begin
        if (pos_arst) begin
            q <= '0;
        end else if (en) begin
            q.value <= d.value;
            q.taint <= d.taint | en_flow;
        end else begin
            // value holds, taint keeps accumulating
            q.taint <= q.taint | en_flow;
        end
    end

endmodule

`default_nettype wire

// File: src/taint_shadow_mem.sv
`timescale 1ns/1ps
`default_nettype none

module taint_shadow_mem (
    input  logic                            pos_clk,
    input  logic                            pos_arst,
    input  taint_pkg::mem_wr_t              wr,
    input  taint_pkg::mem_rd_t              rd,
    output taint_pkg::taint_t               rd_taint,
    output logic [taint_pkg::mem_depth-1:0] word_tainted
);
    import taint_pkg::*;

    taint_t mem [mem_depth];

    taint_t wr_old;
    taint_t wr_new;
    taint_t rd_word;

    assign wr_old = mem[wr.addr];

    // a tainted address could hit any word, so the whole word is tainted
    always_comb begin
        if (|wr.addr_taint) begin
            wr_new = '1;
        end else begin
            wr_new = wr.en_taint | (wr.en & wr.data_taint) | (~wr.en & wr_old);
        end
    end

    assign rd_word = mem[rd.addr] | {data_w{|rd.addr_taint}};

    always_ff @(posedge pos_clk or posedge pos_arst) begin
        if (pos_arst) begin
            for (int i = 0; i < mem_depth; i++) begin
                mem[i] <= '0;
            end
        end else begin
            mem[wr.addr] <= wr_new;
        end
    end

    // read sees the word before a same-edge write
    always_ff @(posedge pos_clk or posedge pos_arst) begin
        if (pos_arst) begin
            rd_taint <= '0;
        end else if (rd.en_taint) begin
            rd_taint <= '1;
        end else if (rd.en) begin
            rd_taint <= rd_word;
        end else begin
            rd_taint <= '0;
        end
    end

    for (genvar i = 0; i < mem_depth; i++) begin : g_word
        assign word_tainted[i] = |mem[i];
    end

endmodule

`default_nettype wire

// File: src/taint_track_top.sv
`timescale 1ns/1ps
`default_nettype none

module taint_track_top (
    input  logic                  pos_clk,
    input  logic                  pos_arst,
    input  taint_pkg::op_req_t    op_req,
    output taint_pkg::op_res_t    result,
    input  taint_pkg::mem_wr_t    mem_wr,
    input  taint_pkg::mem_rd_t    mem_rd,
    output taint_pkg::taint_t     rd_taint,
    input  taint_pkg::live_ctl_t  live_ctl,
    output taint_pkg::count_t     live_count
);
    import taint_pkg::*;

    // combinational result ahead of the register
    op_res_t              op_res;
    logic [mem_depth-1:0] word_tainted;

    // compute lane
    taint_op_cell u_op_cell (
        .req (op_req),
        .res (op_res)
    );

    taint_result_reg u_result_reg (
        .pos_clk  (pos_clk),
        .pos_arst (pos_arst),
        .en       (op_req.en),
        .en_taint (op_req.en_taint),
        .d        (op_res),
        .q        (result)
    );

    // storage lane
    taint_shadow_mem u_shadow_mem (
        .pos_clk      (pos_clk),
        .pos_arst     (pos_arst),
        .wr           (mem_wr),
        .rd           (mem_rd),
        .rd_taint     (rd_taint),
        .word_tainted (word_tainted)
    );

    // counts live words of the shadow memory
    taint_liveness_count u_liveness_count (
        .pos_clk      (pos_clk),
        .pos_arst     (pos_arst),
        .ctl          (live_ctl),
        .word_tainted (word_tainted),
        .live_count   (live_count)
    );

endmodule

`default_nettype wire
